// ==== hw/ddr_bridge_settings.svh ====
`ifndef DDR_BRIDGE_SETTINGS_SVH
`define DDR_BRIDGE_SETTINGS_SVH

// app port word, address and command id
`define DDR_DATA_WIDTH 128
`define DDR_ADDR_WIDTH 29
`define DDR_ID_WIDTH 4

// one strobe bit per data byte
`define DDR_STRB_WIDTH (`DDR_DATA_WIDTH / 8)

// fifo depths as log2
`define CMD_FIFO_DEPTH_LOG2 2
`define RSP_FIFO_DEPTH_LOG2 2

// host starts with one credit per command fifo slot
`define CMD_CREDITS (1 << `CMD_FIFO_DEPTH_LOG2)
`define RSP_CREDITS 2

`endif

// ==== hw/ddr_bridge_pkg.sv ====
`default_nettype none

`include "ddr_bridge_settings.svh"

package ddr_bridge_pkg;

    // app command codes
    localparam logic [2:0] app_cmd_write = 3'b000;
    localparam logic [2:0] app_cmd_read = 3'b001;

    // one host command, read or write
    typedef struct packed {
        logic                         is_read;
        logic                         last;
        logic [`DDR_ID_WIDTH-1:0]     id;
        logic [`DDR_ADDR_WIDTH-1:0]   addr;
        logic [`DDR_DATA_WIDTH-1:0]   data;
        logic [`DDR_STRB_WIDTH-1:0]   strb;
    } bridge_cmd_t;

    // read response back to the host
    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0]     id;
        logic                         last;
        logic [`DDR_DATA_WIDTH-1:0]   data;
    } bridge_rsp_t;

    // command and write data channel toward the controller
    typedef struct packed {
        logic                         cmd_en;
        logic [2:0]                   cmd;
        logic [`DDR_ADDR_WIDTH-1:0]   addr;
        logic                         wdf_wren;
        logic                         wdf_end;
        logic [`DDR_DATA_WIDTH-1:0]   wdf_data;
        logic [`DDR_STRB_WIDTH-1:0]   wdf_mask;
    } app_req_t;

    // controller side status and read data
    typedef struct packed {
        logic                         app_rdy;
        logic                         wdf_rdy;
        logic [`DDR_DATA_WIDTH-1:0]   rd_data;
        logic                         rd_valid;
    } app_rsp_t;

endpackage

`default_nettype wire

// ==== hw/cdc_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo #(
    parameter type payload_t = logic,
    parameter int DEPTH_LOG2 = 2
) (
    input  wire                   wr_clk,
    input  wire                   wr_resetn,
    input  wire                   wr_en,
    input  wire payload_t         wr_data,
    output logic                  full,
    output logic [DEPTH_LOG2:0]   freed_slots,
    input  wire                   rd_clk,
    input  wire                   rd_resetn,
    input  wire                   rd_en,
    output payload_t              rd_data,
    output logic                  empty
);

    localparam int depth = 1 << DEPTH_LOG2;

    // pointers carry one extra wrap bit
    typedef logic [DEPTH_LOG2:0] ptr_t;

    payload_t mem [depth];

    ptr_t wr_bin;
    ptr_t wr_bin_next;
    ptr_t wr_gray;
    ptr_t rd_bin;
    ptr_t rd_bin_next;
    ptr_t rd_gray;

    // read pointer as seen by the writer
    ptr_t rq1_gray;
    ptr_t rq2_gray;
    ptr_t rq2_bin;
    ptr_t rq2_bin_q;

    // write pointer as seen by the reader
    ptr_t wq1_gray;
    ptr_t wq2_gray;

    logic wr_fire;
    logic rd_fire;

    function automatic ptr_t gray_to_bin(ptr_t g);
        ptr_t b;
        b[DEPTH_LOG2] = g[DEPTH_LOG2];
        for (int i = DEPTH_LOG2 - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // write domain
    assign wr_fire = wr_en && !full;
    assign wr_bin_next = wr_bin + ptr_t'(wr_fire);
    assign rq2_bin = gray_to_bin(rq2_gray);

    // same slot, opposite lap
    assign full = (wr_bin[DEPTH_LOG2] != rq2_bin[DEPTH_LOG2]) &&
                  (wr_bin[DEPTH_LOG2-1:0] == rq2_bin[DEPTH_LOG2-1:0]);

    // slots the reader released since the previous write clock
    assign freed_slots = rq2_bin - rq2_bin_q;

    always_ff @(posedge wr_clk) begin
        if (!wr_resetn) begin
            wr_bin <= '0;
            wr_gray <= '0;
            rq1_gray <= '0;
            rq2_gray <= '0;
            rq2_bin_q <= '0;
        end else begin
            wr_bin <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            rq1_gray <= rd_gray;
            rq2_gray <= rq1_gray;
            rq2_bin_q <= rq2_bin;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[DEPTH_LOG2-1:0]] <= wr_data;
        end
    end

    // read domain
    assign rd_fire = rd_en && !empty;
    assign rd_bin_next = rd_bin + ptr_t'(rd_fire);
    assign empty = (rd_gray == wq2_gray);

    // fall-through head of the queue
    assign rd_data = mem[rd_bin[DEPTH_LOG2-1:0]];

    always_ff @(posedge rd_clk) begin
        if (!rd_resetn) begin
            rd_bin <= '0;
            rd_gray <= '0;
            wq1_gray <= '0;
            wq2_gray <= '0;
        end else begin
            rd_bin <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            wq1_gray <= wr_gray;
            wq2_gray <= wq1_gray;
        end
    end

    // writer must respect full, reader must respect empty
    wr_when_full: assert property (@(posedge wr_clk) disable iff (!wr_resetn)
        !(wr_en && full));

    rd_when_empty: assert property (@(posedge rd_clk) disable iff (!rd_resetn)
        !(rd_en && empty));

endmodule

`default_nettype wire

// ==== hw/credit_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module credit_ctrl (
    input  wire                               clk_if,
    input  wire                               resetn,
    input  wire [`CMD_FIFO_DEPTH_LOG2:0]      freed_slots,
    output logic                              cmd_credit,
    input  wire ddr_bridge_pkg::bridge_rsp_t  rsp_fifo_data,
    input  wire                               rsp_fifo_empty,
    output logic                              rsp_fifo_pop,
    input  wire                               rsp_credit,
    output logic                              rsp_valid,
    output ddr_bridge_pkg::bridge_rsp_t       rsp
);

    localparam int owed_w = $clog2(`CMD_CREDITS + 1);
    localparam int rsp_cnt_w = $clog2(`RSP_CREDITS + 1);

    // command credits freed but not yet handed back
    logic [owed_w-1:0] owed;

    // response credits currently held by the bridge
    logic [rsp_cnt_w-1:0] rsp_cnt;

    // one credit per cycle, the rest wait in owed
    assign cmd_credit = (owed != '0);

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            owed <= '0;
        end else begin
            owed <= owed + owed_w'(freed_slots) - owed_w'(cmd_credit);
        end
    end

    // forward a response only while a credit is held
    assign rsp_fifo_pop = !rsp_fifo_empty && (rsp_cnt != '0);
    assign rsp_valid = rsp_fifo_pop;
    assign rsp = rsp_fifo_data;

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            rsp_cnt <= rsp_cnt_w'(`RSP_CREDITS);
        end else begin
            rsp_cnt <= rsp_cnt + rsp_cnt_w'(rsp_credit) - rsp_cnt_w'(rsp_fifo_pop);
        end
    end

    // host returns no more response credits than it was given
    rsp_credit_bound: assert property (@(posedge clk_if) disable iff (!resetn)
        rsp_cnt <= rsp_cnt_w'(`RSP_CREDITS));

    // freed slots can never outrun what the host spent
    cmd_owed_bound: assert property (@(posedge clk_if) disable iff (!resetn)
        owed <= owed_w'(`CMD_CREDITS));

endmodule

`default_nettype wire

// ==== hw/app_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module app_sequencer (
    input  wire                               ui_clk,
    input  wire                               ui_resetn,
    input  wire ddr_bridge_pkg::bridge_cmd_t  cmd_data,
    input  wire                               cmd_empty,
    output logic                              cmd_pop,
    output ddr_bridge_pkg::app_req_t          app_req,
    input  wire ddr_bridge_pkg::app_rsp_t     app_rsp,
    input  wire                               rsp_full,
    output logic                              rsp_push,
    output ddr_bridge_pkg::bridge_rsp_t       rsp_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_write_issue,
        st_read_issue,
        st_read_wait
    } state_t;

    state_t state;

    // request currently presented on the app port
    logic                         cmd_en_q;
    logic                         wren_q;
    logic [2:0]                   cmd_q;
    logic [`DDR_ADDR_WIDTH-1:0]   addr_q;
    logic [`DDR_DATA_WIDTH-1:0]   wdata_q;
    logic [`DDR_STRB_WIDTH-1:0]   mask_q;

    // read context kept until the data returns
    logic [`DDR_ID_WIDTH-1:0]     rd_id_q;
    logic                         rd_last_q;

    logic wr_taken;
    logic rd_taken;
    logic can_load;
    logic rsp_room;

    assign wr_taken = (state == st_write_issue) && app_rsp.app_rdy && app_rsp.wdf_rdy;
    assign rd_taken = (state == st_read_issue) && app_rsp.app_rdy;

    // push in flight is not yet reflected in full
    assign rsp_room = !rsp_full && !rsp_push;

    // a taken write frees the port in the same cycle, so writes stream
    assign can_load = (state == st_idle) || wr_taken;
    assign cmd_pop = can_load && !cmd_empty && (!cmd_data.is_read || rsp_room);

    always_ff @(posedge ui_clk) begin
        if (!ui_resetn) begin
            state <= st_idle;
            cmd_en_q <= 1'b0;
            wren_q <= 1'b0;
            rsp_push <= 1'b0;
        end else begin
            rsp_push <= 1'b0;
            case (state)
                st_idle, st_write_issue: begin
                    if (wr_taken) begin
                        cmd_en_q <= 1'b0;
                        wren_q <= 1'b0;
                        state <= st_idle;
                    end
                    if (cmd_pop) begin
                        cmd_en_q <= 1'b1;
                        wren_q <= !cmd_data.is_read;
                        state <= cmd_data.is_read ? st_read_issue : st_write_issue;
                    end
                end
                st_read_issue: begin
                    if (rd_taken) begin
                        cmd_en_q <= 1'b0;
                        state <= st_read_wait;
                    end
                end
                st_read_wait: begin
                    if (app_rsp.rd_valid) begin
                        rsp_push <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge ui_clk) begin
        if (cmd_pop) begin
            cmd_q <= cmd_data.is_read ? ddr_bridge_pkg::app_cmd_read
                                      : ddr_bridge_pkg::app_cmd_write;
            addr_q <= cmd_data.addr;
            wdata_q <= cmd_data.data;
            // app mask is active high, strobe inverted
            mask_q <= ~cmd_data.strb;
            rd_id_q <= cmd_data.id;
            rd_last_q <= cmd_data.last;
        end
        if ((state == st_read_wait) && app_rsp.rd_valid) begin
            rsp_data.id <= rd_id_q;
            rsp_data.last <= rd_last_q;
            rsp_data.data <= app_rsp.rd_data;
        end
    end

    // single beat, so end marks every write
    always_comb begin
        app_req.cmd_en = cmd_en_q;
        app_req.cmd = cmd_q;
        app_req.addr = addr_q;
        app_req.wdf_wren = wren_q;
        app_req.wdf_end = wren_q;
        app_req.wdf_data = wdata_q;
        app_req.wdf_mask = mask_q;
    end

    // controller only returns data for the read in flight
    rd_valid_in_wait: assert property (@(posedge ui_clk) disable iff (!ui_resetn)
        app_rsp.rd_valid |-> (state == st_read_wait));

    // a request the port has not taken stays put
    req_held: assert property (@(posedge ui_clk) disable iff (!ui_resetn)
        (app_req.cmd_en && !(wr_taken || rd_taken)) |=> $stable(app_req));

endmodule

`default_nettype wire

// ==== hw/ddr_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module ddr_bridge_top (
    input  wire                               clk_if,
    input  wire                               ui_clk,
    input  wire                               resetn,
    input  wire                               cmd_valid,
    input  wire ddr_bridge_pkg::bridge_cmd_t  cmd,
    output wire                               cmd_credit,
    output wire                               rsp_valid,
    output wire ddr_bridge_pkg::bridge_rsp_t  rsp,
    input  wire                               rsp_credit,
    output wire ddr_bridge_pkg::app_req_t     app_req,
    input  wire ddr_bridge_pkg::app_rsp_t     app_rsp
);

    // command path, clk_if to ui_clk
    wire [`CMD_FIFO_DEPTH_LOG2:0]       cmd_freed;
    wire ddr_bridge_pkg::bridge_cmd_t   cmd_head;
    wire                                cmd_empty;
    wire                                cmd_pop;

    // response path, ui_clk to clk_if
    wire ddr_bridge_pkg::bridge_rsp_t   seq_rsp;
    wire ddr_bridge_pkg::bridge_rsp_t   rsp_head;
    wire                                rsp_push;
    wire                                rsp_full;
    wire                                rsp_empty;
    wire                                rsp_pop;

    // host credits keep this from filling
    cdc_fifo #(
        .payload_t  (ddr_bridge_pkg::bridge_cmd_t),
        .DEPTH_LOG2 (`CMD_FIFO_DEPTH_LOG2)
    ) cmd_fifo_i (
        .wr_clk      (clk_if),
        .wr_resetn   (resetn),
        .wr_en       (cmd_valid),
        .wr_data     (cmd),
        .full        (),
        .freed_slots (cmd_freed),
        .rd_clk      (ui_clk),
        .rd_resetn   (resetn),
        .rd_en       (cmd_pop),
        .rd_data     (cmd_head),
        .empty       (cmd_empty)
    );

    app_sequencer app_sequencer_i (
        .ui_clk    (ui_clk),
        .ui_resetn (resetn),
        .cmd_data  (cmd_head),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .app_req   (app_req),
        .app_rsp   (app_rsp),
        .rsp_full  (rsp_full),
        .rsp_push  (rsp_push),
        .rsp_data  (seq_rsp)
    );

    cdc_fifo #(
        .payload_t  (ddr_bridge_pkg::bridge_rsp_t),
        .DEPTH_LOG2 (`RSP_FIFO_DEPTH_LOG2)
    ) rsp_fifo_i (
        .wr_clk      (ui_clk),
        .wr_resetn   (resetn),
        .wr_en       (rsp_push),
        .wr_data     (seq_rsp),
        .full        (rsp_full),
        .freed_slots (),
        .rd_clk      (clk_if),
        .rd_resetn   (resetn),
        .rd_en       (rsp_pop),
        .rd_data     (rsp_head),
        .empty       (rsp_empty)
    );

    credit_ctrl credit_ctrl_i (
        .clk_if         (clk_if),
        .resetn         (resetn),
        .freed_slots    (cmd_freed),
        .cmd_credit     (cmd_credit),
        .rsp_fifo_data  (rsp_head),
        .rsp_fifo_empty (rsp_empty),
        .rsp_fifo_pop   (rsp_pop),
        .rsp_credit     (rsp_credit),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp)
    );

endmodule

`default_nettype wire

// ==== test/app_port_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module app_port_model (
    input  wire                               ui_clk,
    input  wire                               resetn,
    input  wire ddr_bridge_pkg::app_req_t     app_req,
    output ddr_bridge_pkg::app_rsp_t          app_rsp
);

    logic [`DDR_DATA_WIDTH-1:0] mem [logic [`DDR_ADDR_WIDTH-1:0]];
    logic [1:0]                 rd_cnt;
    logic [`DDR_ADDR_WIDTH-1:0] rd_addr;

    function automatic logic [`DDR_DATA_WIDTH-1:0] peek(input logic [`DDR_ADDR_WIDTH-1:0] a);
        return mem.exists(a) ? mem[a] : '0;
    endfunction

    always @(posedge ui_clk) begin : model_proc
        logic [`DDR_DATA_WIDTH-1:0] word;
        if (!resetn) begin
            app_rsp <= '0;
            rd_cnt <= '0;
        end else begin
            app_rsp.app_rdy <= ($urandom % 4) != 0;
            app_rsp.wdf_rdy <= ($urandom % 8) != 0;
            app_rsp.rd_valid <= 1'b0;
            // fixed read latency of 3 cycles
            if (rd_cnt != 0) begin
                rd_cnt <= rd_cnt - 1;
                if (rd_cnt == 1) begin
                    app_rsp.rd_valid <= 1'b1;
                    app_rsp.rd_data <= peek(rd_addr);
                end
            end
            if (app_req.cmd_en && app_rsp.app_rdy) begin
                if (app_req.cmd == ddr_bridge_pkg::app_cmd_read) begin
                    rd_addr <= app_req.addr;
                    rd_cnt <= 2'd3;
                end else if (app_req.cmd == ddr_bridge_pkg::app_cmd_write &&
                             app_req.wdf_wren && app_req.wdf_end && app_rsp.wdf_rdy) begin
                    word = peek(app_req.addr);
                    // mask bit set means keep the old byte
                    for (int i = 0; i < `DDR_STRB_WIDTH; i++) begin
                        if (!app_req.wdf_mask[i]) begin
                            word[8*i +: 8] = app_req.wdf_data[8*i +: 8];
                        end
                    end
                    mem[app_req.addr] = word;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_ddr_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_bridge_settings.svh"

module tb_ddr_bridge;

    localparam int timeout = 4000;

    logic                         clk_if;
    logic                         ui_clk;
    logic                         resetn;
    logic                         cmd_valid;
    ddr_bridge_pkg::bridge_cmd_t  cmd;
    logic                         cmd_credit;
    logic                         rsp_valid;
    ddr_bridge_pkg::bridge_rsp_t  rsp;
    logic                         rsp_credit = 1'b0;
    ddr_bridge_pkg::app_req_t     app_req;
    ddr_bridge_pkg::app_rsp_t     app_rsp;

    int sent = 0;
    int credited = 0;
    int rsp_owed = 0;
    int held_seen = 0;
    logic hold_credits = 1'b0;
    int errors = 0;
    int checks = 0;
    logic aborted = 1'b0;
    ddr_bridge_pkg::bridge_rsp_t exp_q[$];
    ddr_bridge_pkg::bridge_rsp_t got_q[$];

    ddr_bridge_top dut_i (.*);

    app_port_model model_i (.ui_clk(ui_clk), .resetn(resetn), .app_req(app_req),
                            .app_rsp(app_rsp));

    initial begin
        clk_if = 1'b0;
        forever #50 clk_if = ~clk_if;
    end

    initial begin
        ui_clk = 1'b0;
        forever #35 ui_clk = ~ui_clk;
    end

    // host side counts credits, collects responses and hands rsp credits back
    always @(posedge clk_if) begin : host_mon
        int n;
        if (cmd_credit) begin
            credited <= credited + 1;
            checks++;
            // a credit comes back only for a command in flight
            assert (credited < sent) else begin
                $display("ERR %0t cmd_credit got 1 exp 0 with %0d sent and %0d credited",
                         $time, sent, credited);
                errors++;
            end
        end
        n = rsp_owed + (rsp_valid ? 1 : 0);
        if (rsp_valid) begin
            got_q.push_back(rsp);
            if (hold_credits) held_seen <= held_seen + 1;
        end
        if (!hold_credits && n > 0) begin
            rsp_credit <= 1'b1;
            n--;
        end else begin
            rsp_credit <= 1'b0;
        end
        rsp_owed = n;
    end

    function automatic int avail();
        return `CMD_CREDITS - sent + credited;
    endfunction

    task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic send_cmd(input ddr_bridge_pkg::bridge_cmd_t c);
        int t;
        t = 0;
        while (avail() == 0 && t <= timeout) begin
            cmd_valid <= 1'b0;
            @(posedge clk_if);
            t++;
        end
        if (t > timeout) begin
            $display("no command credit came back within %0d cycles", timeout);
            aborted = 1'b1;
        end else begin
            cmd_valid <= 1'b1;
            cmd <= c;
            sent++;
            @(posedge clk_if);
        end
    endtask

    task automatic wait_done();
        int t;
        t = 0;
        while ((got_q.size() < exp_q.size() || credited != sent) && t <= timeout) begin
            @(posedge clk_if);
            t++;
        end
        if (t > timeout) begin
            $display("responses or command credits missing after %0d cycles", timeout);
            aborted = 1'b1;
        end
    endtask

    task automatic compare_rsps();
        ddr_bridge_pkg::bridge_rsp_t e;
        ddr_bridge_pkg::bridge_rsp_t g;
        check_eq("response count", got_q.size(), exp_q.size());
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            check_eq("rsp.id", g.id, e.id);
            check_eq("rsp.last", g.last, e.last);
            check_eq("rsp.data", g.data, e.data);
        end
    endtask

    initial begin : main
        string names [4];
        int fd;
        int sec;
        int sec_err;
        int last;
        string line;
        byte op;
        logic [`DDR_ID_WIDTH-1:0] id;
        logic [`DDR_ADDR_WIDTH-1:0] addr;
        logic [`DDR_DATA_WIDTH-1:0] data;
        logic [`DDR_DATA_WIDTH-1:0] exp_data;
        logic [`DDR_STRB_WIDTH-1:0] strb;
        ddr_bridge_pkg::bridge_cmd_t c;
        ddr_bridge_pkg::bridge_rsp_t e;

        names = '{"full-strobe write and read", "partial-strobe merge",
                  "command credit burst", "held response credits"};
        cmd_valid = 1'b0;
        cmd = '0;
        resetn = 1'b0;
        void'($urandom(32'h6924c75c));
        repeat (16) @(posedge clk_if);
        resetn <= 1'b1;

        repeat (20) begin
            @(posedge clk_if);
            check_eq("cmd_credit", cmd_credit, 1'b0);
            check_eq("rsp_valid", rsp_valid, 1'b0);
        end
        check_eq("host credits", avail(), `CMD_CREDITS);
        $display("test 1 reset state: %0d errors", errors);

        sec = 0;
        sec_err = errors;
        fd = $fopen("test/bridge_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open test/bridge_trace.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            void'($sscanf(line, "%c %h %h %h %h %h %h", op, id, addr, data, strb, last,
                          exp_data));
            if (op == "S") begin
                cmd_valid <= 1'b0;
                if (sec == 3) begin
                    // let the held reads settle, then only the bridge credits show
                    repeat (300) @(posedge clk_if);
                    check_eq("responses while held", held_seen, `RSP_CREDITS);
                    hold_credits <= 1'b0;
                end
                wait_done();
                if (aborted) break;
                compare_rsps();
                $display("test %0d %s: %0d errors", sec + 2, names[sec], errors - sec_err);
                sec++;
                sec_err = errors;
                if (sec == 3) begin
                    repeat (4) @(posedge clk_if);
                    hold_credits <= 1'b1;
                end
            end else begin
                c.is_read = (op == "R");
                c.last = last[0];
                c.id = id;
                c.addr = addr;
                c.data = data;
                c.strb = strb;
                if (c.is_read) begin
                    e.id = id;
                    e.last = last[0];
                    e.data = exp_data;
                    exp_q.push_back(e);
                end
                send_cmd(c);
            end
        end
        if (fd != 0) $fclose(fd);
        cmd_valid <= 1'b0;

        $display("tests %0d, checks %0d, errors %0d", sec + 1, checks, errors);
        if (!aborted && errors == 0 && sec == 4) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/ddr_bridge_pkg.sv
hw/cdc_fifo.sv
hw/credit_ctrl.sv
hw/app_sequencer.sv
hw/ddr_bridge_top.sv
test/app_port_model.sv
test/tb_ddr_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the bridge testbench, fail on the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir && mkdir -p obj_dir || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_ddr_bridge -o tb_ddr_bridge \
    && ./obj_dir/tb_ddr_bridge > obj_dir/sim.log 2>&1 \
    || { cat obj_dir/sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat obj_dir/sim.log
grep -q "TEST RESULT: FAIL" obj_dir/sim.log && exit 1 || exit 0

// ==== test/bridge_trace.txt ====
# op id addr data strb last expect, all hex; op W write, R read, S ends a section
# expect is the read data; writes carry 0 there
W 1 0000100 00112233445566778899aabbccddeeff ffff 0 0
W 2 0000108 0123456789abcdeffedcba9876543210 ffff 1 0
R 3 0000100 0 0 0 00112233445566778899aabbccddeeff
R 4 0000108 0 0 1 0123456789abcdeffedcba9876543210
S
W 5 0000100 ffeeddccbbaa99887766554433221100 00ff 0 0
W 6 0000108 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa f00f 1 0
R 7 0000100 0 0 0 00112233445566777766554433221100
R 8 0000108 0 0 1 aaaaaaaa89abcdeffedcba98aaaaaaaa
S
W 1 0000200 c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0 ffff 0 0
W 2 0000208 c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1 ffff 0 0
W 3 0000210 c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2 ffff 0 0
W 4 0000218 c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3 ffff 1 0
S
R 9 0000200 0 0 0 c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0
R a 0000208 0 0 0 c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1c1
R b 0000210 0 0 0 c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2c2
R c 0000218 0 0 1 c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3
S
